// ==== rtl/axi_dma_pkg.sv ====
package axi_dma_pkg;

   // awlen holds beats minus one
   localparam int AXI_LEN_W = 8;

   typedef logic [AXI_LEN_W-1:0] axi_len_t;

   // write response code on bresp
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;

   // aligner sequencing
   typedef enum logic [2:0] {
      ALIGN_IDLE,      // wait for the first source word
      ALIGN_CONFIG,    // burst length and edge masks
      ALIGN_FIRST,     // first beat of the burst
      ALIGN_TRANSFER,  // middle beats
      ALIGN_LAST       // last beat of a multi beat burst
   } align_state_t;

   // burst writer phases
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_t;

endpackage

// ==== rtl/wdata_aligner.sv ====
`timescale 1ns/1ps

module wdata_aligner #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  rst,

   input  logic [ADDR_W-1:0]     nbytes,       // transfer bytes minus one

   // packed source stream
   input  logic                  dbus_valid,
   input  logic [ADDR_W-1:0]     dbus_addr,
   input  logic [DATA_W-1:0]     dbus_wdata,
   input  logic [DATA_W/8-1:0]   dbus_wstrb,
   output logic                  dbus_ready,

   // aligned beats to the burst writer
   output logic                  dma_w_valid,
   output logic [ADDR_W-1:0]     dma_w_addr,
   output logic [DATA_W-1:0]     dma_w_wdata,
   output logic [DATA_W/8-1:0]   dma_w_wstrb,
   output axi_dma_pkg::axi_len_t dma_w_len,
   input  logic                  dma_w_ready
);

   localparam int NB    = DATA_W/8;
   localparam int OFF_W = $clog2(NB);

   typedef logic [OFF_W-1:0] lane_t;

   axi_dma_pkg::align_state_t state;
   axi_dma_pkg::align_state_t state_nxt;

   lane_t             off;          // lane of the first payload byte
   lane_t             end_lane;     // lane of the last payload byte
   logic [ADDR_W-1:0] span;
   logic [ADDR_W-1:0] len;          // beats minus one
   logic [ADDR_W-1:0] beat_cnt;     // beats left after the one on the bus
   logic [ADDR_W-1:0] words_left;   // source words still to be taken
   logic [NB-1:0]     first_mask;
   logic [NB-1:0]     last_mask;
   logic [ADDR_W-1:0] base_addr;

   // stage 0 holds the newest word above the previous one
   logic [2*DATA_W-1:0] buf_wdata;
   logic [2*NB-1:0]     buf_wstrb;
   logic [2*DATA_W-1:0] shf_wdata;
   logic [2*NB-1:0]     shf_wstrb;
   // stage 1 is the bus aligned beat
   logic [DATA_W-1:0]   beat_wdata;
   logic [NB-1:0]       beat_wstrb;

   logic start;
   logic in_beat;
   logic need_word;
   logic beat_valid;
   logic advance;
   logic load;

   assign start   = (state == axi_dma_pkg::ALIGN_IDLE) && dbus_valid;
   assign in_beat = (state == axi_dma_pkg::ALIGN_FIRST) ||
                    (state == axi_dma_pkg::ALIGN_TRANSFER) ||
                    (state == axi_dma_pkg::ALIGN_LAST);

   // a beat goes out only when the word behind it is on the source bus
   assign need_word  = |words_left;
   assign beat_valid = in_beat && (!need_word || dbus_valid);
   assign advance    = beat_valid && dma_w_ready;
   assign load       = ((state == axi_dma_pkg::ALIGN_CONFIG) && dbus_valid) || advance;

   assign span     = nbytes + {{(ADDR_W-OFF_W){1'b0}}, off};
   assign end_lane = span[OFF_W-1:0];

   // shift up by the start lane, upper half is the aligned beat
   assign shf_wdata = buf_wdata << {off, 3'b000};
   assign shf_wstrb = buf_wstrb << off;

   always_comb begin
      state_nxt = state;
      case (state)
         axi_dma_pkg::ALIGN_IDLE: begin
            if (dbus_valid)
               state_nxt = axi_dma_pkg::ALIGN_CONFIG;
         end
         axi_dma_pkg::ALIGN_CONFIG: begin
            if (dbus_valid)                            // second word taken
               state_nxt = axi_dma_pkg::ALIGN_FIRST;
         end
         axi_dma_pkg::ALIGN_FIRST,
         axi_dma_pkg::ALIGN_TRANSFER: begin
            if (advance) begin
               if (beat_cnt == '0)                     // single beat burst
                  state_nxt = axi_dma_pkg::ALIGN_IDLE;
               else if (beat_cnt == ADDR_W'(1))
                  state_nxt = axi_dma_pkg::ALIGN_LAST;
               else
                  state_nxt = axi_dma_pkg::ALIGN_TRANSFER;
            end
         end
         axi_dma_pkg::ALIGN_LAST: begin
            if (advance)
               state_nxt = axi_dma_pkg::ALIGN_IDLE;
         end
         default: state_nxt = axi_dma_pkg::ALIGN_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= axi_dma_pkg::ALIGN_IDLE;
         len        <= '0;
         beat_cnt   <= '0;
         words_left <= '0;
      end else begin
         state <= state_nxt;
         if (state == axi_dma_pkg::ALIGN_CONFIG) begin
            len        <= span >> OFF_W;
            beat_cnt   <= span >> OFF_W;
            // payload words plus padding, two of them already taken
            words_left <= nbytes >> OFF_W;
         end else if (advance) begin
            if (beat_cnt != '0)
               beat_cnt <= beat_cnt - ADDR_W'(1);
            if (need_word)
               words_left <= words_left - ADDR_W'(1);
         end
      end
   end

   // datapath, frozen while the writer holds dma_w_ready low
   always_ff @(posedge clk) begin
      if (start) begin
         off       <= dbus_addr[OFF_W-1:0];
         base_addr <= {dbus_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
         buf_wdata <= {dbus_wdata, {DATA_W{1'b0}}};
         buf_wstrb <= {dbus_wstrb, {NB{1'b0}}};
      end else if (load) begin
         buf_wdata  <= {dbus_wdata, buf_wdata[DATA_W +: DATA_W]};
         buf_wstrb  <= {dbus_wstrb, buf_wstrb[NB +: NB]};
         beat_wdata <= shf_wdata[DATA_W +: DATA_W];
         beat_wstrb <= shf_wstrb[NB +: NB];
      end
      if (state == axi_dma_pkg::ALIGN_CONFIG) begin
         first_mask <= {NB{1'b1}} << off;
         last_mask  <= {NB{1'b1}} >> ~end_lane;
      end
   end

   always_comb begin
      dma_w_wstrb = '0;
      case (state)
         axi_dma_pkg::ALIGN_FIRST: begin
            dma_w_wstrb = beat_wstrb & first_mask;
            if (beat_cnt == '0)
               dma_w_wstrb = dma_w_wstrb & last_mask;
         end
         axi_dma_pkg::ALIGN_TRANSFER: dma_w_wstrb = beat_wstrb;
         axi_dma_pkg::ALIGN_LAST:     dma_w_wstrb = beat_wstrb & last_mask;
         default:                     dma_w_wstrb = '0;
      endcase
   end

   // two words at burst start, then one per accepted beat
   always_comb begin
      case (state)
         axi_dma_pkg::ALIGN_IDLE:   dbus_ready = dbus_valid;
         axi_dma_pkg::ALIGN_CONFIG: dbus_ready = 1'b1;
         default:                   dbus_ready = advance && need_word;
      endcase
   end

   assign dma_w_valid = beat_valid;
   assign dma_w_addr  = base_addr;
   assign dma_w_wdata = beat_wdata;

   // saturate at the awlen field maximum
   assign dma_w_len = (|len[ADDR_W-1:axi_dma_pkg::AXI_LEN_W]) ? '1 :
                      len[axi_dma_pkg::AXI_LEN_W-1:0];

endmodule

// ==== rtl/axi_burst_writer.sv ====
`timescale 1ns/1ps

module axi_burst_writer #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                   clk,
   input  logic                   rst,

   // aligned beats from the aligner
   input  logic                   dma_w_valid,
   input  logic [ADDR_W-1:0]      dma_w_addr,
   input  logic [DATA_W-1:0]      dma_w_wdata,
   input  logic [DATA_W/8-1:0]    dma_w_wstrb,
   input  axi_dma_pkg::axi_len_t  dma_w_len,
   output logic                   dma_w_ready,

   // write address channel
   output logic                   awvalid,
   output logic [ADDR_W-1:0]      awaddr,
   output axi_dma_pkg::axi_len_t  awlen,
   output logic [2:0]             awsize,
   output logic [1:0]             awburst,
   input  logic                   awready,

   // write data channel
   output logic                   wvalid,
   output logic [DATA_W-1:0]      wdata,
   output logic [DATA_W/8-1:0]    wstrb,
   output logic                   wlast,
   input  logic                   wready,

   // write response channel
   input  logic                   bvalid,
   input  axi_dma_pkg::axi_resp_t bresp,
   output logic                   bready,

   output logic                   done,
   output logic                   resp_err
);

   localparam logic [2:0] BEAT_SIZE  = 3'($clog2(DATA_W/8));   // full bus width beats
   localparam logic [1:0] BURST_INCR = 2'b01;

   axi_dma_pkg::wr_state_t state;
   axi_dma_pkg::axi_len_t  beat_cnt;   // beats done in the data phase

   logic in_data;
   logic w_hs;

   assign in_data = (state == axi_dma_pkg::WR_DATA);
   assign w_hs    = wvalid && wready;

   // address channel
   assign awvalid = (state == axi_dma_pkg::WR_ADDR);
   assign awsize  = BEAT_SIZE;
   assign awburst = BURST_INCR;

   // data channel follows the aligner only in the data phase
   assign wvalid      = in_data && dma_w_valid;
   assign wdata       = dma_w_wdata;
   assign wstrb       = dma_w_wstrb;
   assign wlast       = in_data && (beat_cnt == awlen);
   assign dma_w_ready = in_data && wready;

   assign bready = (state == axi_dma_pkg::WR_RESP);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= axi_dma_pkg::WR_IDLE;
         beat_cnt <= '0;
         done     <= 1'b0;
         resp_err <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            axi_dma_pkg::WR_IDLE: begin
               if (dma_w_valid)                  // first beat is waiting
                  state <= axi_dma_pkg::WR_ADDR;
            end
            axi_dma_pkg::WR_ADDR: begin
               if (awready) begin
                  state    <= axi_dma_pkg::WR_DATA;
                  beat_cnt <= '0;
               end
            end
            axi_dma_pkg::WR_DATA: begin
               if (w_hs) begin
                  if (wlast)
                     state <= axi_dma_pkg::WR_RESP;
                  else
                     beat_cnt <= beat_cnt + axi_dma_pkg::axi_len_t'(1);
               end
            end
            axi_dma_pkg::WR_RESP: begin
               if (bvalid) begin
                  state    <= axi_dma_pkg::WR_IDLE;
                  done     <= 1'b1;
                  resp_err <= (bresp != axi_dma_pkg::RESP_OKAY);
               end
            end
            default: state <= axi_dma_pkg::WR_IDLE;
         endcase
      end
   end

   // burst address and length, held until the next burst
   always_ff @(posedge clk) begin
      if ((state == axi_dma_pkg::WR_IDLE) && dma_w_valid) begin
         awaddr <= dma_w_addr;
         awlen  <= dma_w_len;
      end
   end

endmodule

// ==== rtl/axi_dma_write.sv ====
`timescale 1ns/1ps

module axi_dma_write #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                   clk,
   input  logic                   rst,

   input  logic [ADDR_W-1:0]      nbytes,    // stable until done

   // source stream
   input  logic                   dbus_valid,
   input  logic [ADDR_W-1:0]      dbus_addr,
   input  logic [DATA_W-1:0]      dbus_wdata,
   input  logic [DATA_W/8-1:0]    dbus_wstrb,
   output logic                   dbus_ready,

   // AXI4 write channels
   output logic                   awvalid,
   output logic [ADDR_W-1:0]      awaddr,
   output axi_dma_pkg::axi_len_t  awlen,
   output logic [2:0]             awsize,
   output logic [1:0]             awburst,
   input  logic                   awready,
   output logic                   wvalid,
   output logic [DATA_W-1:0]      wdata,
   output logic [DATA_W/8-1:0]    wstrb,
   output logic                   wlast,
   input  logic                   wready,
   input  logic                   bvalid,
   input  axi_dma_pkg::axi_resp_t bresp,
   output logic                   bready,

   output logic                   done,
   output logic                   resp_err
);

   // aligner to writer
   logic                  dma_w_valid;
   logic [ADDR_W-1:0]     dma_w_addr;
   logic [DATA_W-1:0]     dma_w_wdata;
   logic [DATA_W/8-1:0]   dma_w_wstrb;
   axi_dma_pkg::axi_len_t dma_w_len;
   logic                  dma_w_ready;

   wdata_aligner #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_aligner (
      .clk         (clk),
      .rst         (rst),
      .nbytes      (nbytes),
      .dbus_valid  (dbus_valid),
      .dbus_addr   (dbus_addr),
      .dbus_wdata  (dbus_wdata),
      .dbus_wstrb  (dbus_wstrb),
      .dbus_ready  (dbus_ready),
      .dma_w_valid (dma_w_valid),
      .dma_w_addr  (dma_w_addr),
      .dma_w_wdata (dma_w_wdata),
      .dma_w_wstrb (dma_w_wstrb),
      .dma_w_len   (dma_w_len),
      .dma_w_ready (dma_w_ready)
   );

   axi_burst_writer #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_writer (
      .clk         (clk),
      .rst         (rst),
      .dma_w_valid (dma_w_valid),
      .dma_w_addr  (dma_w_addr),
      .dma_w_wdata (dma_w_wdata),
      .dma_w_wstrb (dma_w_wstrb),
      .dma_w_len   (dma_w_len),
      .dma_w_ready (dma_w_ready),
      .awvalid     (awvalid),
      .awaddr      (awaddr),
      .awlen       (awlen),
      .awsize      (awsize),
      .awburst     (awburst),
      .awready     (awready),
      .wvalid      (wvalid),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wlast       (wlast),
      .wready      (wready),
      .bvalid      (bvalid),
      .bresp       (bresp),
      .bready      (bready),
      .done        (done),
      .resp_err    (resp_err)
   );

endmodule

// ==== tb/axi_mem_slave.sv ====
`timescale 1ns/1ps

module axi_mem_slave #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   slverr,      // answer bursts with SLVERR
   input  logic                   awvalid,
   input  logic [ADDR_W-1:0]      awaddr,
   input  axi_dma_pkg::axi_len_t  awlen,
   input  logic [2:0]             awsize,
   input  logic [1:0]             awburst,
   output logic                   awready,
   input  logic                   wvalid,
   input  logic [DATA_W-1:0]      wdata,
   input  logic [DATA_W/8-1:0]    wstrb,
   input  logic                   wlast,
   output logic                   wready,
   output logic                   bvalid,
   output axi_dma_pkg::axi_resp_t bresp,
   input  logic                   bready,
   output logic [ADDR_W-1:0]      cap_addr,    // awaddr of the last burst
   output axi_dma_pkg::axi_len_t  cap_len,
   output logic [2:0]             cap_size,
   output logic [1:0]             cap_burst,
   output int                     beat_cnt,    // data beats of the last burst
   output int                     wlast_errs
);

   localparam int NB = DATA_W/8;
   localparam axi_dma_pkg::axi_resp_t RESP_SLVERR = 2'b10;

   logic [7:0]        mem [logic [ADDR_W-1:0]];   // sparse byte memory
   logic [ADDR_W-1:0] beat_addr;

   // unwritten bytes read back as this marker
   function automatic logic [7:0] marker_byte(input logic [ADDR_W-1:0] addr);
      logic [7:0] m;
      m = 8'h5a;
      for (int k = 0; k < ADDR_W/8; k++)
         m = m ^ addr[8*k +: 8];
      return m;
   endfunction

   function automatic logic [7:0] peek(input logic [ADDR_W-1:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      return marker_byte(addr);
   endfunction

   initial begin
      logic b_taken;
      logic b_due;
      awready    = 1'b0;
      wready     = 1'b0;
      bvalid     = 1'b0;
      bresp      = axi_dma_pkg::RESP_OKAY;
      cap_addr   = '0;
      cap_len    = '0;
      cap_size   = '0;
      cap_burst  = '0;
      beat_cnt   = 0;
      wlast_errs = 0;
      beat_addr  = '0;
      forever begin
         @(posedge clk);
         b_taken = bvalid && bready;
         b_due   = 1'b0;
         if (!rst) begin
            if (awvalid && awready) begin
               cap_addr  = awaddr;
               cap_len   = awlen;
               cap_size  = awsize;
               cap_burst = awburst;
               beat_addr = awaddr;
               beat_cnt  = 0;
            end
            if (wvalid && wready) begin
               for (int j = 0; j < NB; j++) begin
                  if (wstrb[j])
                     mem[beat_addr + ADDR_W'(j)] = wdata[8*j +: 8];
               end
               if (wlast != (beat_cnt == int'(cap_len)))
                  wlast_errs++;
               beat_addr = beat_addr + ADDR_W'(NB);
               beat_cnt++;
               b_due = wlast;
            end
         end
         #1;
         awready = ($urandom % 4) != 0;   // about one stall in four
         wready  = ($urandom % 4) != 0;
         if (b_taken)
            bvalid = 1'b0;
         if (b_due) begin
            bvalid = 1'b1;
            bresp  = slverr ? RESP_SLVERR : axi_dma_pkg::RESP_OKAY;
         end
      end
   end

endmodule

// ==== tb/tb_axi_dma_write.sv ====
`timescale 1ns/1ps

module tb_axi_dma_write;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int NB         = DATA_W/8;
   localparam int OFF_W      = $clog2(NB);
   localparam int N_XFER     = 40;
   localparam int ERR_XFER   = 20;     // slave returns SLVERR here
   localparam int MAX_CYCLES = N_XFER * (256*4 + 50);

   localparam axi_dma_pkg::axi_resp_t RESP_SLVERR = 2'b10;
   localparam logic [1:0]             BURST_INCR  = 2'b01;

   logic                   clk;
   logic                   rst;
   logic [ADDR_W-1:0]      nbytes;
   logic                   dbus_valid;
   logic [ADDR_W-1:0]      dbus_addr;
   logic [DATA_W-1:0]      dbus_wdata;
   logic [NB-1:0]          dbus_wstrb;
   logic                   dbus_ready;
   logic                   awvalid;
   logic [ADDR_W-1:0]      awaddr;
   axi_dma_pkg::axi_len_t  awlen;
   logic [2:0]             awsize;
   logic [1:0]             awburst;
   logic                   awready;
   logic                   wvalid;
   logic [DATA_W-1:0]      wdata;
   logic [NB-1:0]          wstrb;
   logic                   wlast;
   logic                   wready;
   logic                   bvalid;
   axi_dma_pkg::axi_resp_t bresp;
   logic                   bready;
   logic                   done;
   logic                   resp_err;

   // slave side
   logic                   slverr;
   logic [ADDR_W-1:0]      cap_addr;
   axi_dma_pkg::axi_len_t  cap_len;
   logic [2:0]             cap_size;
   logic [1:0]             cap_burst;
   int                     beat_cnt;
   int                     wlast_errs;

   logic [ADDR_W-1:0] xfer_start;
   int                xfer_n;
   logic [7:0]        payload[$];

   int   n_checks    = 0;
   int   value_errs  = 0;
   int   other_errs  = 0;
   int   done_cnt    = 0;
   int   wlast_seen  = 0;
   int   cycles      = 0;
   logic err_at_done = 1'b0;

   axi_dma_write #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) DUT (.*);

   axi_mem_slave #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      if (!rst && done) begin
         done_cnt++;
         err_at_done = resp_err;   // status that goes with this pulse
      end
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: no end of run after %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   task automatic check_len(input string name, input axi_dma_pkg::axi_len_t exp,
                            input axi_dma_pkg::axi_len_t act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                             input logic [ADDR_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_size(input string name, input logic [2:0] exp, input logic [2:0] act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_burst(input string name, input logic [1:0] exp, input logic [1:0] act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_resp(input string name, input axi_dma_pkg::axi_resp_t exp,
                             input axi_dma_pkg::axi_resp_t act);
      n_checks++;
      if (act !== exp) begin
         value_errs++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // AXI size code, a beat carries 2**code bytes
   function automatic logic [2:0] size_code(input int bytes);
      logic [2:0] code;
      code = '0;
      for (int c = 0; c < 8; c++) begin
         if ((1 << c) == bytes)
            code = 3'(c);
      end
      return code;
   endfunction

   task automatic make_transfer(input int t);
      int off;
      xfer_start = {8'($urandom), 8'(t + 1), 1'b0, 15'($urandom)};   // own region each
      if (t % 8 == 5)
         xfer_start[OFF_W-1:0] = '0;
      off = int'(xfer_start[OFF_W-1:0]);
      case (t % 8)
         2:       xfer_n = 1 + int'($urandom % (NB - off));          // inside one word
         5:       xfer_n = NB * (1 + int'($urandom % 256));          // whole words
         default: xfer_n = 1 + int'($urandom % (256*NB - off));
      endcase
      payload.delete();
      for (int i = 0; i < xfer_n; i++)
         payload.push_back(8'($urandom));
   endtask

   // packed little endian words plus one zero word at the end
   task automatic send_stream();
      int   words;
      int   k;
      logic hs;
      words = (xfer_n - 1) / NB + 2;
      k = 0;
      while (k < words) begin
         dbus_valid = 1'b1;
         dbus_addr  = xfer_start;
         for (int j = 0; j < NB; j++) begin
            dbus_wdata[8*j +: 8] = (k*NB + j < xfer_n) ? payload[k*NB + j] : 8'h00;
            dbus_wstrb[j]        = (k*NB + j < xfer_n);
         end
         @(negedge clk);
         hs = dbus_valid && dbus_ready;
         @(posedge clk);
         #1;
         if (hs)
            k++;
      end
      dbus_valid = 1'b0;
      dbus_wdata = '0;
      dbus_wstrb = '0;
   endtask

   task automatic wait_done(input int count);
      while (done_cnt < count) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_transfer(input int t);
      logic [ADDR_W-1:0]      base;
      logic [ADDR_W-1:0]      last;
      logic [ADDR_W-1:0]      a;
      axi_dma_pkg::axi_resp_t exp_resp;
      int                     beats;
      int                     i;
      base  = xfer_start & ~ADDR_W'(NB - 1);
      last  = xfer_start + ADDR_W'(xfer_n - 1);
      beats = int'((last >> OFF_W) - (base >> OFF_W)) + 1;
      check_addr($sformatf("xfer %0d awaddr", t), base, cap_addr);
      check_len($sformatf("xfer %0d awlen", t), axi_dma_pkg::axi_len_t'(beats - 1), cap_len);
      check_size($sformatf("xfer %0d awsize", t), size_code(NB), cap_size);
      check_burst($sformatf("xfer %0d awburst", t), BURST_INCR, cap_burst);
      if (beat_cnt != int'(cap_len) + 1) begin
         other_errs++;
         $display("xfer %0d: slave saw %0d data beats for awlen %0d", t, beat_cnt, cap_len);
      end
      if (wlast_errs != wlast_seen) begin
         other_errs++;
         $display("xfer %0d: wlast was not high on the final beat only", t);
         wlast_seen = wlast_errs;
      end
      if (done_cnt != t + 1) begin
         other_errs++;
         $display("xfer %0d: %0d done pulses so far, expected %0d", t, done_cnt, t + 1);
      end
      exp_resp = (t == ERR_XFER) ? RESP_SLVERR : axi_dma_pkg::RESP_OKAY;
      check_resp($sformatf("xfer %0d status", t), exp_resp,
                 err_at_done ? RESP_SLVERR : axi_dma_pkg::RESP_OKAY);
      // whole burst window plus one byte on each side
      for (int k = -1; k <= beats*NB; k++) begin
         a = base + ADDR_W'(k);
         i = k - int'(xfer_start - base);
         if (i >= 0 && i < xfer_n)
            check_byte($sformatf("xfer %0d data %h", t, a), payload[i], u_mem.peek(a));
         else
            check_byte($sformatf("xfer %0d guard %h", t, a), u_mem.marker_byte(a),
                       u_mem.peek(a));
      end
   endtask

   initial begin
      int unsigned seed_ret;
      seed_ret   = $urandom(32'h7a0b_316d);
      rst        = 1'b1;
      nbytes     = '0;
      dbus_valid = 1'b0;
      dbus_addr  = '0;
      dbus_wdata = '0;
      dbus_wstrb = '0;
      slverr     = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int t = 0; t < N_XFER; t++) begin
         make_transfer(t);
         slverr = (t == ERR_XFER);
         nbytes = ADDR_W'(xfer_n - 1);   // count minus one
         send_stream();
         wait_done(t + 1);
         repeat (3) @(posedge clk);     // room for a stray second done
         #1;
         check_transfer(t);
      end
      $display("checks %0d, value errors %0d, other errors %0d",
               n_checks, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
rtl/axi_dma_pkg.sv
rtl/wdata_aligner.sv
rtl/axi_burst_writer.sv
rtl/axi_dma_write.sv
tb/axi_mem_slave.sv
tb/tb_axi_dma_write.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_axi_dma_write
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
